//--- source/usb_host_pkg.sv
package usb_host_pkg;

  // Two-bit PID type, shared by all packet groups
  typedef logic [1:0] pid_type_t;

  // Token types
  localparam pid_type_t TOK_OUT   = 2'b00;
  localparam pid_type_t TOK_SOF   = 2'b01;
  localparam pid_type_t TOK_IN    = 2'b10;
  localparam pid_type_t TOK_SETUP = 2'b11;

  // Handshake types
  localparam pid_type_t HSK_ACK = 2'b00;
  localparam pid_type_t HSK_NAK = 2'b10;

  // Data types
  localparam pid_type_t DATA0 = 2'b00;
  localparam pid_type_t DATA1 = 2'b10;

  // Low group of the PID nibble, selects the packet group
  localparam logic [1:0] PID_TOKEN_LOW = 2'b01;
  localparam logic [1:0] PID_HSK_LOW   = 2'b10;
  localparam logic [1:0] PID_DATA_LOW  = 2'b11;

  typedef enum logic [1:0] {
    KIND_NONE  = 2'd0,
    KIND_TOKEN = 2'd1,
    KIND_HSK   = 2'd2,
    KIND_DATA  = 2'd3
  } pkt_kind_t;

  // Token payload, least significant field first on the wire
  typedef union packed {
    struct packed {
      logic [4:0] crc5;
      logic [3:0] endp;
      logic [6:0] addr;
    } ep;
    struct packed {
      logic [4:0]  crc5;
      logic [10:0] frame;
    } frm;
  } token_payload_u;

  // Residual of a good data packet, in the bit-reflected register form
  localparam logic [15:0] CRC16_RESIDUAL = 16'hB001;

  // CRC5 over the 11 token bits, returned ready to place in the payload
  function automatic logic [4:0] usb_crc5(input logic [10:0] data);
    logic [4:0] crc;
    crc = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      if (crc[0] ^ data[i]) begin
        crc = (crc >> 1) ^ 5'h14;
      end else begin
        crc = crc >> 1;
      end
    end
    return ~crc;
  endfunction

  // One byte step of CRC16, LSB first, x^16 + x^15 + x^2 + 1 reflected
  function automatic logic [15:0] usb_crc16(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ 16'hA001;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

//--- source/usb_tx_request.sv
module usb_tx_request
  import usb_host_pkg::*;
(
  input  logic           clock,
  input  logic           arst_n_i,
  input  logic           tok_send_i,
  input  pid_type_t      tok_type_i,
  input  token_payload_u tok_payload_i,
  input  logic           hsk_send_i,
  input  pid_type_t      hsk_type_i,
  input  logic           dat_send_i,
  input  pid_type_t      dat_type_i,
  input  logic           enc_finished_i,
  output pkt_kind_t      req_kind_o,
  output pid_type_t      req_type_o,
  output token_payload_u req_payload_o,
  output logic           busy_o,
  output logic           done_o
);

  token_payload_u tok_crc;

  // CRC5 always covers the low 11 bits, the SOF frame view spans them all
  always_comb begin
    tok_crc = tok_payload_i;
    tok_crc.frm.crc5 = usb_crc5(tok_payload_i.frm.frame);
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_o     <= 1'b0;
      done_o     <= 1'b0;
      req_kind_o <= KIND_NONE;
    end else begin
      done_o <= busy_o && enc_finished_i;
      if (!busy_o) begin
        // Token wins over handshake, handshake over data
        if (tok_send_i) begin
          busy_o     <= 1'b1;
          req_kind_o <= KIND_TOKEN;
        end else if (hsk_send_i) begin
          busy_o     <= 1'b1;
          req_kind_o <= KIND_HSK;
        end else if (dat_send_i) begin
          busy_o     <= 1'b1;
          req_kind_o <= KIND_DATA;
        end
      end else if (enc_finished_i) begin
        busy_o     <= 1'b0;
        req_kind_o <= KIND_NONE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!busy_o) begin
      if (tok_send_i) begin
        req_type_o    <= tok_type_i;
        req_payload_o <= tok_crc;
      end else if (hsk_send_i) begin
        req_type_o <= hsk_type_i;
      end else if (dat_send_i) begin
        req_type_o <= dat_type_i;
      end
    end
  end

endmodule

//--- source/usb_pkt_encoder.sv
module usb_pkt_encoder
  import usb_host_pkg::*;
#(
  parameter int MAX_DATA_BYTES = 64
) (
  input  logic           clock,
  input  logic           arst_n_i,
  input  pkt_kind_t      req_kind_i,
  input  pid_type_t      req_type_i,
  input  token_payload_u req_payload_i,
  input  logic           busy_i,
  input  logic           dat_valid_i,
  input  logic           dat_last_i,
  input  logic [7:0]     dat_data_i,
  input  logic           enc_ready_i,
  output logic           dat_ready_o,
  output logic           enc_valid_o,
  output logic           enc_last_o,
  output logic [7:0]     enc_data_o,
  output logic           enc_finished_o
);

  localparam int CNT_W = $clog2(MAX_DATA_BYTES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MAX_DATA_BYTES - 1);

  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_PID    = 3'd1;
  localparam logic [2:0] ST_TOK_LO = 3'd2;
  localparam logic [2:0] ST_TOK_HI = 3'd3;
  localparam logic [2:0] ST_DATA   = 3'd4;
  localparam logic [2:0] ST_CRC_LO = 3'd5;
  localparam logic [2:0] ST_CRC_HI = 3'd6;
  localparam logic [2:0] ST_FLUSH  = 3'd7;

  logic [2:0]       state_q;
  logic [15:0]      crc_q;
  logic [CNT_W-1:0] count_q;
  logic [1:0]       low_grp;
  logic [3:0]       pid_lo;
  logic             xfer;

  always_comb begin
    case (req_kind_i)
      KIND_TOKEN: low_grp = PID_TOKEN_LOW;
      KIND_DATA:  low_grp = PID_DATA_LOW;
      default:    low_grp = PID_HSK_LOW;
    endcase
  end

  assign pid_lo = {req_type_i, low_grp};
  assign xfer   = enc_valid_o && enc_ready_i;

  // Last byte sits in the output register while flushing, ready means it leaves
  assign enc_finished_o = (state_q == ST_FLUSH) && enc_ready_i;

  always_comb begin
    enc_valid_o = 1'b0;
    enc_last_o  = 1'b0;
    enc_data_o  = 8'h00;
    dat_ready_o = 1'b0;
    case (state_q)
      ST_PID: begin
        enc_valid_o = 1'b1;
        enc_last_o  = (req_kind_i == KIND_HSK);
        enc_data_o  = {~pid_lo, pid_lo};
      end
      ST_TOK_LO: begin
        enc_valid_o = 1'b1;
        enc_data_o  = req_payload_i[7:0];
      end
      ST_TOK_HI: begin
        enc_valid_o = 1'b1;
        enc_last_o  = 1'b1;
        enc_data_o  = req_payload_i[15:8];
      end
      ST_DATA: begin
        enc_valid_o = dat_valid_i;
        enc_data_o  = dat_data_i;
        dat_ready_o = enc_ready_i;
      end
      ST_CRC_LO: begin
        enc_valid_o = 1'b1;
        enc_data_o  = ~crc_q[7:0];
      end
      ST_CRC_HI: begin
        enc_valid_o = 1'b1;
        enc_last_o  = 1'b1;
        enc_data_o  = ~crc_q[15:8];
      end
      default: enc_valid_o = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (busy_i) begin
            state_q <= ST_PID;
          end
        end
        ST_PID: begin
          count_q <= '0;
          if (xfer) begin
            case (req_kind_i)
              KIND_TOKEN: state_q <= ST_TOK_LO;
              KIND_DATA:  state_q <= ST_DATA;
              default:    state_q <= ST_FLUSH;
            endcase
          end
        end
        ST_TOK_LO: if (xfer) state_q <= ST_TOK_HI;
        ST_TOK_HI: if (xfer) state_q <= ST_FLUSH;
        ST_DATA: begin
          if (xfer) begin
            count_q <= count_q + 1'b1;
            if (dat_last_i || count_q == CNT_LAST) begin
              state_q <= ST_CRC_LO;
            end
          end
        end
        ST_CRC_LO: if (xfer) state_q <= ST_CRC_HI;
        ST_CRC_HI: if (xfer) state_q <= ST_FLUSH;
        default: if (enc_finished_o) state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == ST_PID) begin
      crc_q <= 16'hFFFF;
    end else if (state_q == ST_DATA && xfer) begin
      crc_q <= usb_crc16(crc_q, dat_data_i);
    end
  end

endmodule

//--- source/usb_tx_stream.sv
module usb_tx_stream (
  input  logic       clock,
  input  logic       arst_n_i,
  input  logic       enc_valid_i,
  input  logic       enc_last_i,
  input  logic [7:0] enc_data_i,
  input  logic       tx_ready_i,
  output logic       enc_ready_o,
  output logic       tx_valid_o,
  output logic       tx_last_o,
  output logic [7:0] tx_data_o
);

  // Space is free when the register is empty or its byte leaves this cycle
  assign enc_ready_o = !tx_valid_o || tx_ready_i;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_valid_o <= 1'b0;
    end else if (enc_ready_o) begin
      tx_valid_o <= enc_valid_i;
    end
  end

  // Byte and last flag hold while the sink stalls
  always_ff @(posedge clock) begin
    if (enc_ready_o && enc_valid_i) begin
      tx_last_o <= enc_last_i;
      tx_data_o <= enc_data_i;
    end
  end

endmodule

//--- source/usb_pkt_decoder.sv
module usb_pkt_decoder
  import usb_host_pkg::*;
#(
  parameter int MAX_DATA_BYTES = 64
) (
  input  logic           clock,
  input  logic           arst_n_i,
  input  logic           rx_valid_i,
  input  logic           rx_last_i,
  input  logic [7:0]     rx_data_i,
  output logic           tok_recv_o,
  output pid_type_t      tok_type_o,
  output token_payload_u tok_payload_o,
  output logic           hsk_recv_o,
  output pid_type_t      hsk_type_o,
  output logic           dat_recv_o,
  output pid_type_t      dat_type_o,
  output logic           out_valid_o,
  output logic           out_last_o,
  output logic [7:0]     out_data_o,
  output logic           usb_sof_o,
  output logic           crc_err_o
);

  // Bytes after the PID saturate beyond the longest legal packet
  localparam int CNT_W = $clog2(MAX_DATA_BYTES + 4);
  localparam logic [CNT_W-1:0] LEN_MAX = CNT_W'(MAX_DATA_BYTES + 1);
  localparam logic [CNT_W-1:0] LEN_SAT = {CNT_W{1'b1}};

  logic             first_q;
  pkt_kind_t        kind_q;
  pid_type_t        type_q;
  logic [7:0]       tok_lo_q;
  logic [15:0]      crc_q;
  logic [CNT_W-1:0] len_q;
  logic [7:0]       sh0_q;
  logic [7:0]       sh1_q;

  pkt_kind_t      pid_kind;
  pkt_kind_t      cur_kind;
  pid_type_t      cur_type;
  token_payload_u tok_word;
  logic [15:0]    crc_next;
  logic           tok_good;
  logic           dat_good;
  logic           pkt_good;
  logic           fwd;

  always_comb begin
    pid_kind = KIND_NONE;
    if (rx_data_i[7:4] == ~rx_data_i[3:0]) begin
      case (rx_data_i[1:0])
        PID_TOKEN_LOW: pid_kind = KIND_TOKEN;
        // ACK, NAK, DATA0 and DATA1 all have type bit 0 clear
        PID_HSK_LOW:  pid_kind = rx_data_i[2] ? KIND_NONE : KIND_HSK;
        PID_DATA_LOW: pid_kind = rx_data_i[2] ? KIND_NONE : KIND_DATA;
        default:      pid_kind = KIND_NONE;
      endcase
    end
  end

  assign cur_kind = first_q ? pid_kind : kind_q;
  assign cur_type = first_q ? rx_data_i[3:2] : type_q;
  assign tok_word = {rx_data_i, tok_lo_q};
  assign crc_next = usb_crc16(crc_q, rx_data_i);

  assign tok_good = !first_q && len_q == CNT_W'(1) &&
                    usb_crc5(tok_word.frm.frame) == tok_word.frm.crc5;
  assign dat_good = !first_q && len_q >= CNT_W'(2) && len_q <= LEN_MAX &&
                    crc_next == CRC16_RESIDUAL;

  always_comb begin
    case (cur_kind)
      KIND_TOKEN: pkt_good = tok_good;
      KIND_HSK:   pkt_good = first_q;
      KIND_DATA:  pkt_good = dat_good;
      default:    pkt_good = 1'b0;
    endcase
  end

  // Two bytes held back so the CRC16 never reaches the out stream
  assign fwd = !first_q && kind_q == KIND_DATA && len_q >= CNT_W'(2) && len_q <= LEN_MAX;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      first_q <= 1'b1;
      kind_q  <= KIND_NONE;
      len_q   <= '0;
    end else if (rx_valid_i) begin
      first_q <= rx_last_i;
      if (first_q) begin
        kind_q <= pid_kind;
        len_q  <= '0;
      end else if (len_q != LEN_SAT) begin
        len_q <= len_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_valid_i) begin
      if (first_q) begin
        type_q <= rx_data_i[3:2];
        crc_q  <= 16'hFFFF;
      end else begin
        crc_q <= crc_next;
        sh0_q <= rx_data_i;
        sh1_q <= sh0_q;
      end
      if (!first_q && len_q == '0) begin
        tok_lo_q <= rx_data_i;
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tok_recv_o  <= 1'b0;
      hsk_recv_o  <= 1'b0;
      dat_recv_o  <= 1'b0;
      usb_sof_o   <= 1'b0;
      crc_err_o   <= 1'b0;
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= rx_valid_i && fwd;
      tok_recv_o  <= rx_valid_i && rx_last_i && pkt_good && cur_kind == KIND_TOKEN;
      hsk_recv_o  <= rx_valid_i && rx_last_i && pkt_good && cur_kind == KIND_HSK;
      dat_recv_o  <= rx_valid_i && rx_last_i && pkt_good && cur_kind == KIND_DATA;
      usb_sof_o   <= rx_valid_i && rx_last_i && pkt_good && cur_kind == KIND_TOKEN &&
                     cur_type == TOK_SOF;
      crc_err_o   <= rx_valid_i && rx_last_i && !pkt_good;
    end
  end

  // Report fields load together with their pulse
  always_ff @(posedge clock) begin
    if (rx_valid_i && fwd) begin
      out_data_o <= sh1_q;
      out_last_o <= rx_last_i;
    end
    if (rx_valid_i && rx_last_i && pkt_good) begin
      case (cur_kind)
        KIND_TOKEN: begin
          tok_type_o    <= cur_type;
          tok_payload_o <= tok_word;
        end
        KIND_HSK:  hsk_type_o <= cur_type;
        KIND_DATA: dat_type_o <= cur_type;
        default: ;
      endcase
    end
  end

endmodule

//--- source/usb_host_packet_top.sv
module usb_host_packet_top
  import usb_host_pkg::*;
#(
  parameter int MAX_DATA_BYTES = 64
) (
  input  logic           clock,
  input  logic           arst_n_i,
  input  logic           tok_send_i,
  input  pid_type_t      tok_type_i,
  input  token_payload_u tok_payload_i,
  input  logic           hsk_send_i,
  input  pid_type_t      hsk_type_i,
  input  logic           dat_send_i,
  input  pid_type_t      dat_type_i,
  input  logic           dat_valid_i,
  input  logic           dat_last_i,
  input  logic [7:0]     dat_data_i,
  input  logic           tx_ready_i,
  input  logic           rx_valid_i,
  input  logic           rx_last_i,
  input  logic [7:0]     rx_data_i,
  output logic           busy_o,
  output logic           done_o,
  output logic           dat_ready_o,
  output logic           tx_valid_o,
  output logic           tx_last_o,
  output logic [7:0]     tx_data_o,
  output logic           tok_recv_o,
  output pid_type_t      tok_type_o,
  output token_payload_u tok_payload_o,
  output logic           hsk_recv_o,
  output pid_type_t      hsk_type_o,
  output logic           dat_recv_o,
  output pid_type_t      dat_type_o,
  output logic           out_valid_o,
  output logic           out_last_o,
  output logic [7:0]     out_data_o,
  output logic           usb_sof_o,
  output logic           crc_err_o
);

  pkt_kind_t      req_kind;
  pid_type_t      req_type;
  token_payload_u req_payload;
  logic           enc_finished;
  logic           enc_valid;
  logic           enc_last;
  logic [7:0]     enc_data;
  logic           enc_ready;

  usb_tx_request u_tx_request (
    .clock          (clock),
    .arst_n_i       (arst_n_i),
    .tok_send_i     (tok_send_i),
    .tok_type_i     (tok_type_i),
    .tok_payload_i  (tok_payload_i),
    .hsk_send_i     (hsk_send_i),
    .hsk_type_i     (hsk_type_i),
    .dat_send_i     (dat_send_i),
    .dat_type_i     (dat_type_i),
    .enc_finished_i (enc_finished),
    .req_kind_o     (req_kind),
    .req_type_o     (req_type),
    .req_payload_o  (req_payload),
    .busy_o         (busy_o),
    .done_o         (done_o)
  );

  usb_pkt_encoder #(
    .MAX_DATA_BYTES (MAX_DATA_BYTES)
  ) u_pkt_encoder (
    .clock          (clock),
    .arst_n_i       (arst_n_i),
    .req_kind_i     (req_kind),
    .req_type_i     (req_type),
    .req_payload_i  (req_payload),
    .busy_i         (busy_o),
    .dat_valid_i    (dat_valid_i),
    .dat_last_i     (dat_last_i),
    .dat_data_i     (dat_data_i),
    .enc_ready_i    (enc_ready),
    .dat_ready_o    (dat_ready_o),
    .enc_valid_o    (enc_valid),
    .enc_last_o     (enc_last),
    .enc_data_o     (enc_data),
    .enc_finished_o (enc_finished)
  );

  usb_tx_stream u_tx_stream (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .enc_valid_i (enc_valid),
    .enc_last_i  (enc_last),
    .enc_data_i  (enc_data),
    .tx_ready_i  (tx_ready_i),
    .enc_ready_o (enc_ready),
    .tx_valid_o  (tx_valid_o),
    .tx_last_o   (tx_last_o),
    .tx_data_o   (tx_data_o)
  );

  usb_pkt_decoder #(
    .MAX_DATA_BYTES (MAX_DATA_BYTES)
  ) u_pkt_decoder (
    .clock         (clock),
    .arst_n_i      (arst_n_i),
    .rx_valid_i    (rx_valid_i),
    .rx_last_i     (rx_last_i),
    .rx_data_i     (rx_data_i),
    .tok_recv_o    (tok_recv_o),
    .tok_type_o    (tok_type_o),
    .tok_payload_o (tok_payload_o),
    .hsk_recv_o    (hsk_recv_o),
    .hsk_type_o    (hsk_type_o),
    .dat_recv_o    (dat_recv_o),
    .dat_type_o    (dat_type_o),
    .out_valid_o   (out_valid_o),
    .out_last_o    (out_last_o),
    .out_data_o    (out_data_o),
    .usb_sof_o     (usb_sof_o),
    .crc_err_o     (crc_err_o)
  );

endmodule

//--- bench/usb_host_packet_checks.svh
`ifndef USB_HOST_PACKET_CHECKS_SVH
`define USB_HOST_PACKET_CHECKS_SVH

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_type(input string what, input pid_type_t exp, input pid_type_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", cur_name, what, exp, act);
    end
  endtask

  task automatic check_payload(input string what, input token_payload_u exp,
                               input token_payload_u act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", cur_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
    end
  endtask

  // PID byte is the type and group nibble with its complement on top
  function automatic logic [7:0] pid_byte(input pid_type_t t, input logic [1:0] grp);
    logic [3:0] nib;
    nib = {t, grp};
    return {~nib, nib};
  endfunction

  task automatic expect_token(input pid_type_t t, input token_payload_u p);
    exp_bytes.delete();
    exp_bytes.push_back(pid_byte(t, PID_TOKEN_LOW));
    exp_bytes.push_back(p[7:0]);
    exp_bytes.push_back(p[15:8]);
  endtask

  task automatic expect_hsk(input pid_type_t t);
    exp_bytes.delete();
    exp_bytes.push_back(pid_byte(t, PID_HSK_LOW));
  endtask

  // Full data packet as it appears on the wire, CRC16 low byte first
  function automatic byte_q_t data_packet(input pid_type_t t, input byte_q_t d);
    byte_q_t pkt;
    logic [15:0] crc;
    crc = ref_crc16(d);
    pkt.push_back(pid_byte(t, PID_DATA_LOW));
    foreach (d[i]) begin
      pkt.push_back(d[i]);
    end
    pkt.push_back(crc[7:0]);
    pkt.push_back(crc[15:8]);
    return pkt;
  endfunction

  task automatic compare_tx_stream();
    check_count("tx byte count", exp_bytes.size(), tx_got.size());
    for (int i = 0; i < exp_bytes.size() && i < tx_got.size(); i++) begin
      check_byte($sformatf("tx byte %0d", i), exp_bytes[i], tx_got[i]);
      check_flag($sformatf("tx last %0d", i), i == exp_bytes.size() - 1, last_got[i]);
    end
  endtask

`endif

//--- bench/usb_host_packet_tb.sv
module usb_host_packet_tb;
  import usb_host_pkg::*;

  localparam int NUM_TESTS      = 13;
  localparam int MAX_DATA_BYTES = 64;
  localparam int WAIT_CYCLES    = 200;

  typedef logic [7:0] byte_q_t[$];

  logic           clock;
  logic           arst_n_i;
  logic           tok_send_i;
  pid_type_t      tok_type_i;
  token_payload_u tok_payload_i;
  logic           hsk_send_i;
  pid_type_t      hsk_type_i;
  logic           dat_send_i;
  pid_type_t      dat_type_i;
  logic           dat_valid_i = 1'b0;
  logic           dat_last_i  = 1'b0;
  logic [7:0]     dat_data_i  = 8'h00;
  logic           tx_ready_i  = 1'b1;
  logic           rx_valid_i  = 1'b0;
  logic           rx_last_i   = 1'b0;
  logic [7:0]     rx_data_i   = 8'h00;
  logic           busy_o;
  logic           done_o;
  logic           dat_ready_o;
  logic           tx_valid_o;
  logic           tx_last_o;
  logic [7:0]     tx_data_o;
  logic           tok_recv_o;
  pid_type_t      tok_type_o;
  token_payload_u tok_payload_o;
  logic           hsk_recv_o;
  pid_type_t      hsk_type_o;
  logic           dat_recv_o;
  pid_type_t      dat_type_o;
  logic           out_valid_o;
  logic           out_last_o;
  logic [7:0]     out_data_o;
  logic           usb_sof_o;
  logic           crc_err_o;

  int      seed = 98;
  string   cur_name;
  int      errors = 0;
  int      err_base;
  int      tests_run = 0;
  int      tests_failed = 0;
  logic    loop_en = 1'b1;
  byte_q_t exp_bytes;
  byte_q_t tx_got;
  byte_q_t out_got;
  byte_q_t dat_src;
  byte_q_t dir_q;
  logic    last_got[$];
  logic    out_last_got[$];
  logic    ready_pat[$];
  int      src_idx = 0;
  int      dir_idx = 0;
  int      ready_idx = 0;
  logic    got_tok, got_hsk, got_dat, got_sof, got_err;

  usb_host_packet_top #(
    .MAX_DATA_BYTES (MAX_DATA_BYTES)
  ) dut (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Independent CRC5, shifted MSB first and mirrored into wire order at the end
  function automatic logic [4:0] ref_crc5(input logic [10:0] bits);
    logic [4:0] r;
    logic [4:0] res;
    logic       fb;
    r = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb = bits[i] ^ r[4];
      r  = {r[3:0], 1'b0};
      if (fb) r = r ^ 5'h05;
    end
    r = ~r;
    for (int i = 0; i < 5; i++) res[i] = r[4-i];
    return res;
  endfunction

  // CRC16 with polynomial 8005, result mirrored so bits 7:0 go out first
  function automatic logic [15:0] ref_crc16(input byte_q_t d);
    logic [15:0] r;
    logic [15:0] res;
    logic        fb;
    r = 16'hFFFF;
    foreach (d[n]) begin
      for (int i = 0; i < 8; i++) begin
        fb = d[n][i] ^ r[15];
        r  = {r[14:0], 1'b0};
        if (fb) r = r ^ 16'h8005;
      end
    end
    r = ~r;
    for (int i = 0; i < 16; i++) res[i] = r[15-i];
    return res;
  endfunction

  `include "usb_host_packet_checks.svh"

  // Payload source, moves on after each accepted byte
  always @(posedge clock) begin
    if (dat_valid_i && dat_ready_o) src_idx = src_idx + 1;
    if (src_idx < dat_src.size()) begin
      dat_valid_i <= 1'b1;
      dat_last_i  <= (src_idx == dat_src.size() - 1);
      dat_data_i  <= dat_src[src_idx];
    end else begin
      dat_valid_i <= 1'b0;
      dat_last_i  <= 1'b0;
    end
  end

  // Sink ready, follows a random pattern when one is loaded
  always @(posedge clock) begin
    if (ready_idx < ready_pat.size()) begin
      tx_ready_i <= ready_pat[ready_idx];
      ready_idx = ready_idx + 1;
    end else begin
      tx_ready_i <= 1'b1;
    end
  end

  // Receive side fed from accepted tx bytes, or from a byte list
  always @(posedge clock) begin
    if (loop_en) begin
      rx_valid_i <= tx_valid_o && tx_ready_i;
      rx_last_i  <= tx_last_o;
      rx_data_i  <= tx_data_o;
    end else if (dir_idx < dir_q.size()) begin
      rx_valid_i <= 1'b1;
      rx_last_i  <= (dir_idx == dir_q.size() - 1);
      rx_data_i  <= dir_q[dir_idx];
      dir_idx = dir_idx + 1;
    end else begin
      rx_valid_i <= 1'b0;
    end
  end

  always @(posedge clock) begin
    if (tx_valid_o && tx_ready_i) begin
      tx_got.push_back(tx_data_o);
      last_got.push_back(tx_last_o);
    end
    if (out_valid_o) begin
      out_got.push_back(out_data_o);
      out_last_got.push_back(out_last_o);
    end
  end

  always @(posedge clock) begin
    if (done_o) compare_tx_stream();
  end

  initial begin
    #(NUM_TESTS * WAIT_CYCLES * 40);
    $display("watchdog: tests did not finish within %0d time units",
             NUM_TESTS * WAIT_CYCLES * 40);
    $display("** FAIL **");
    $finish;
  end

  task automatic start_test(input string name);
    cur_name = name;
    err_base = errors;
    tx_got.delete();
    last_got.delete();
    out_got.delete();
    out_last_got.delete();
  endtask

  task automatic end_test();
    tests_run++;
    if (errors > err_base) begin
      tests_failed++;
      $display("test %s: failed", cur_name);
    end else begin
      $display("test %s: passed", cur_name);
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(posedge clock);
      n++;
    end while (!done_o && n < WAIT_CYCLES);
    if (!done_o) begin
      errors++;
      $display("%s: no done pulse within %0d cycles", cur_name, WAIT_CYCLES);
    end
  endtask

  task automatic wait_report();
    int n;
    n = 0;
    do begin
      @(posedge clock);
      n++;
    end while (!(tok_recv_o || hsk_recv_o || dat_recv_o || crc_err_o) && n < WAIT_CYCLES);
    got_tok = tok_recv_o;
    got_hsk = hsk_recv_o;
    got_dat = dat_recv_o;
    got_sof = usb_sof_o;
    got_err = crc_err_o;
    if (!(got_tok || got_hsk || got_dat || got_err)) begin
      errors++;
      $display("%s: decoder gave no receive report within %0d cycles", cur_name, WAIT_CYCLES);
    end
    // Let the collector take the last out byte
    @(posedge clock);
  endtask

  task automatic check_reset_state();
    start_test("reset_state");
    @(posedge clock);
    check_flag("busy_o", 1'b0, busy_o);
    check_flag("done_o", 1'b0, done_o);
    check_flag("dat_ready_o", 1'b0, dat_ready_o);
    check_flag("tx_valid_o", 1'b0, tx_valid_o);
    check_flag("tok_recv_o", 1'b0, tok_recv_o);
    check_flag("hsk_recv_o", 1'b0, hsk_recv_o);
    check_flag("dat_recv_o", 1'b0, dat_recv_o);
    check_flag("out_valid_o", 1'b0, out_valid_o);
    check_flag("usb_sof_o", 1'b0, usb_sof_o);
    check_flag("crc_err_o", 1'b0, crc_err_o);
    end_test();
  endtask

  task automatic send_token(input string name, input pid_type_t t, input token_payload_u p);
    token_payload_u want;
    want = p;
    want.frm.crc5 = ref_crc5(p.frm.frame);
    start_test(name);
    expect_token(t, want);
    @(posedge clock);
    tok_send_i    <= 1'b1;
    tok_type_i    <= t;
    tok_payload_i <= p;
    @(posedge clock);
    tok_send_i <= 1'b0;
    wait_done();
    wait_report();
    check_flag("tok_recv_o", 1'b1, got_tok);
    check_flag("usb_sof_o", t == TOK_SOF, got_sof);
    check_flag("crc_err_o", 1'b0, got_err);
    check_type("tok_type_o", t, tok_type_o);
    check_payload("tok_payload_o", want, tok_payload_o);
    end_test();
  endtask

  task automatic send_hsk(input string name, input pid_type_t t);
    start_test(name);
    expect_hsk(t);
    @(posedge clock);
    hsk_send_i <= 1'b1;
    hsk_type_i <= t;
    @(posedge clock);
    hsk_send_i <= 1'b0;
    wait_done();
    wait_report();
    check_flag("hsk_recv_o", 1'b1, got_hsk);
    check_flag("crc_err_o", 1'b0, got_err);
    check_type("hsk_type_o", t, hsk_type_o);
    end_test();
  endtask

  task automatic send_data(input string name, input pid_type_t t, input logic stall);
    byte_q_t     d;
    logic [31:0] rnd;
    int          n;
    start_test(name);
    rnd = $random(seed);
    n = stall ? 8 : int'(rnd[2:0]) + 1;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      d.push_back(rnd[7:0]);
    end
    exp_bytes = data_packet(t, d);
    @(posedge clock);
    if (stall) begin
      ready_idx = 0;
      ready_pat.delete();
      for (int i = 0; i < 64; i++) begin
        rnd = $random(seed);
        ready_pat.push_back(rnd[0]);
      end
    end
    src_idx = 0;
    dat_src = d;
    dat_send_i <= 1'b1;
    dat_type_i <= t;
    @(posedge clock);
    dat_send_i <= 1'b0;
    wait_done();
    wait_report();
    ready_pat.delete();
    check_flag("dat_recv_o", 1'b1, got_dat);
    check_flag("crc_err_o", 1'b0, got_err);
    check_type("dat_type_o", t, dat_type_o);
    check_count("out byte count", n, out_got.size());
    for (int i = 0; i < n && i < out_got.size(); i++) begin
      check_byte($sformatf("out byte %0d", i), d[i], out_got[i]);
      check_flag($sformatf("out last %0d", i), i == n - 1, out_last_got[i]);
    end
    end_test();
  endtask

  task automatic send_corrupt(input string name);
    byte_q_t     d;
    byte_q_t     pkt;
    logic [31:0] rnd;
    logic [15:0] flip;
    start_test(name);
    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      d.push_back(rnd[7:0]);
    end
    pkt = data_packet(DATA1, d);
    rnd = $random(seed);
    flip = 16'h0001 << rnd[3:0];
    pkt[pkt.size()-2] = pkt[pkt.size()-2] ^ flip[7:0];
    pkt[pkt.size()-1] = pkt[pkt.size()-1] ^ flip[15:8];
    @(posedge clock);
    dir_idx = 0;
    dir_q = pkt;
    loop_en = 1'b0;
    wait_report();
    check_flag("crc_err_o", 1'b1, got_err);
    check_flag("dat_recv_o", 1'b0, got_dat);
    check_flag("tok_recv_o", 1'b0, got_tok);
    check_flag("hsk_recv_o", 1'b0, got_hsk);
    loop_en = 1'b1;
    dir_q.delete();
    end_test();
  endtask

  initial begin
    token_payload_u pl;
    arst_n_i      = 1'b0;
    tok_send_i    = 1'b0;
    tok_type_i    = '0;
    tok_payload_i = '0;
    hsk_send_i    = 1'b0;
    hsk_type_i    = '0;
    dat_send_i    = 1'b0;
    dat_type_i    = '0;
    repeat (10) @(posedge clock);
    arst_n_i <= 1'b1;
    check_reset_state();

    // Address 09, endpoint 1, CRC5 left for the DUT to fill in
    pl = '0;
    pl.ep.addr = 7'h09;
    pl.ep.endp = 4'h1;
    send_token("token_in", TOK_IN, pl);
    send_token("token_out", TOK_OUT, pl);
    send_token("token_setup", TOK_SETUP, pl);
    pl = '0;
    pl.frm.frame = 11'h123;
    send_token("sof_frame_123", TOK_SOF, pl);

    send_hsk("hsk_ack", HSK_ACK);
    send_hsk("hsk_nak", HSK_NAK);

    send_data("data0_first", DATA0, 1'b0);
    send_data("data1_first", DATA1, 1'b0);
    send_data("data0_second", DATA0, 1'b0);
    send_data("data1_second", DATA1, 1'b0);
    send_data("data_backpressure", DATA1, 1'b1);
    send_corrupt("data_bad_crc");

    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+bench
source/usb_host_pkg.sv
source/usb_tx_request.sv
source/usb_pkt_encoder.sv
source/usb_tx_stream.sv
source/usb_pkt_decoder.sv
source/usb_host_packet_top.sv
bench/usb_host_packet_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the USB host packet engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module usb_host_packet_tb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vusb_host_packet_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
  exit 0
fi
exit 1
